// File: src.f
source/board_pkg.sv
source/uart_rx.sv
source/word_loader.sv
source/word_mem.sv
source/debug_ctrl.sv
source/seg_scan.sv
source/board_top.sv
tests/board_asserts.sv
tests/board_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module board_tb -f src.f -o board_sim

output=$(./obj_dir/board_sim 2>&1) || true
echo "$output"

if echo "$output" | grep -q "ALL CHECKS PASSED"; then
  exit 0
fi
exit 1

// File: tests/board_tb.sv
`timescale 1ns/1ps

module board_tb;

  logic        clk;
  logic        rst_n;
  logic        rx;
  logic        prog;
  logic        addr_up;
  logic        addr_dn;
  logic [7:0]  an;
  logic [6:0]  sev_out;
  logic [15:0] led;

  integer      seed = 96288;
  int          wr_count = 0;
  int          writes_exp = 0;
  int          n_groups;
  logic [31:0] word;
  logic [31:0] model_mem [0:1023];
  logic [9:0]  model_load;
  logic [9:0]  model_view;

  board_top dut (.*);

  always #20 clk = ~clk;

  // memory writes seen on the loader output
  always @(posedge clk) begin
    if (dut.wr_en) begin
      wr_count <= wr_count + 1;
    end
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("CHECKS FAILED");
    $fatal(1, "run stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] expected,
                          input logic [31:0] actual);
    if (actual !== expected) begin
      $display("** Error at %0t ns: %s expected 0x%0h, got 0x%0h",
               $time, name, expected, actual);
      abort_run("a checked value did not match the model");
    end
  endtask

  // drive and sample 2 ns after the rising edge
  task automatic step_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #2;
    end
  endtask

  // active low segment code built from the lit segments a..g
  function automatic logic [6:0] seg_code(input logic [3:0] nib);
    logic [6:0] lit;
    case (nib)
      4'h0: lit = 7'b1111110;
      4'h1: lit = 7'b0110000;
      4'h2: lit = 7'b1101101;
      4'h3: lit = 7'b1111001;
      4'h4: lit = 7'b0110011;
      4'h5: lit = 7'b1011011;
      4'h6: lit = 7'b1011111;
      4'h7: lit = 7'b1110000;
      4'h8: lit = 7'b1111111;
      4'h9: lit = 7'b1111011;
      4'ha: lit = 7'b1110111;
      4'hb: lit = 7'b0011111;
      4'hc: lit = 7'b1001110;
      4'hd: lit = 7'b0111101;
      4'he: lit = 7'b1001111;
      4'hf: lit = 7'b1000111;
    endcase
    return ~lit;
  endfunction

  // 8N1 frame sent lsb first and followed by a random idle gap
  task automatic send_byte(input logic [7:0] b);
    int gap;
    rx = 1'b0;
    step_cycles(board_pkg::clks_per_bit);
    for (int i = 0; i < 8; i++) begin
      rx = b[i];
      step_cycles(board_pkg::clks_per_bit);
    end
    rx = 1'b1;
    step_cycles(board_pkg::clks_per_bit);
    gap = 1 + ($random(seed) & 3);
    step_cycles(gap);
  endtask

  task automatic send_word(input logic [31:0] w);
    for (int i = 0; i < 4; i++) begin
      send_byte(w[8*i +: 8]);
    end
  endtask

  task automatic wait_writes(input int n);
    int waited;
    waited = 0;
    while (wr_count < n && waited < 4 * board_pkg::clks_per_bit) begin
      step_cycles(1);
      waited++;
    end
    if (wr_count < n) begin
      abort_run("no memory write followed a complete word");
    end
  endtask

  // one word in program mode and the load address shown after it
  task automatic load_word();
    word = $random(seed);
    send_word(word);
    model_mem[model_load] = word;
    model_load = model_load + 10'd1;
    writes_exp++;
    wait_writes(writes_exp);
    step_cycles(2);
    check_eq("led", 32'(model_load), 32'(led));
  endtask

  task automatic press_button(input logic up, input logic dn);
    addr_up = up;
    addr_dn = dn;
    step_cycles(1);
    addr_up = 1'b0;
    addr_dn = 1'b0;
    if (up && !dn) begin
      model_view = model_view + 10'd1;
    end else if (dn && !up) begin
      model_view = model_view - 10'd1;
    end
    step_cycles(4);
  endtask

  task automatic check_view();
    check_eq("rd_addr", 32'(model_view), 32'(dut.rd_addr));
    check_eq("led", 32'(model_mem[model_view][15:0]), 32'(led));
  endtask

  task automatic scan_digits();
    logic [31:0] w;
    logic [7:0]  seen;
    logic [7:0]  an_exp;
    int          k;
    int          k_prev;
    w = model_mem[model_view];
    seen = '0;
    k_prev = -1;
    // nibble register picks up the word on later ticks
    step_cycles(2 * board_pkg::scan_div);
    repeat (16 * board_pkg::scan_div) begin
      k = 0;
      for (int i = 0; i < 8; i++) begin
        if (!an[i]) begin
          k = i;
        end
      end
      an_exp = ~(8'd1 << k);
      check_eq("an", 32'(an_exp), 32'(an));
      // each tick moves the scan one digit up
      if (k_prev >= 0 && k != k_prev) begin
        check_eq("scan digit", 32'((k_prev + 1) % 8), 32'(k));
      end
      check_eq("sev_out", 32'(seg_code(w[4*k +: 4])), 32'(sev_out));
      seen[k] = 1'b1;
      k_prev = k;
      step_cycles(1);
    end
    check_eq("digits scanned", 32'hff, 32'(seen));
  endtask

  initial begin
    clk = 1'b0;
    rst_n = 1'b0;
    rx = 1'b1;
    prog = 1'b0;
    addr_up = 1'b0;
    addr_dn = 1'b0;
    model_load = '0;
    model_view = '0;
    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;
    check_eq("an", 32'hfe, 32'(an));
    check_eq("led", 32'h0, 32'(led));

    prog = 1'b1;
    step_cycles(3);
    check_eq("led", 32'h0, 32'(led));
    n_groups = 2 + ($random(seed) & 3);
    repeat (n_groups) load_word();
    // partial group that the next prog rising edge has to discard
    send_byte(8'($random(seed)));

    // readback through the view address
    prog = 1'b0;
    step_cycles(4);
    check_view();
    repeat (n_groups - 1) begin
      press_button(1'b1, 1'b0);
      check_view();
    end
    scan_digits();

    // bytes with prog low never reach memory
    send_word($random(seed));
    step_cycles(4);
    check_eq("write count", 32'(writes_exp), 32'(wr_count));
    check_view();
    press_button(1'b1, 1'b1);
    check_view();
    while (model_view != 10'd0) begin
      press_button(1'b0, 1'b1);
      check_view();
    end
    press_button(1'b0, 1'b1);
    check_eq("rd_addr", 32'd1023, 32'(dut.rd_addr));
    press_button(1'b1, 1'b0);
    check_view();

    // second session overwrites from word 0
    prog = 1'b1;
    step_cycles(3);
    check_eq("led", 32'h0, 32'(led));
    model_load = '0;
    load_word();
    prog = 1'b0;
    step_cycles(4);
    check_view();
    press_button(1'b1, 1'b0);
    check_view();

    $display("ALL CHECKS PASSED");
    $finish;
  end

  // bound by the longest traffic the run can produce
  initial begin
    int frames;
    int cycles;
    frames = (5 + 2) * 4 + 1;
    cycles = frames * (10 * board_pkg::clks_per_bit + 4) + 20 * 5
             + 20 * board_pkg::scan_div + 100;
    #(2 * cycles * 40);
    abort_run("timeout: the run did not finish in the expected time");
  end

endmodule : board_tb

// File: tests/board_asserts.sv
`timescale 1ns/1ps

module board_asserts (
  input logic                         clk,
  input logic                         rst_n,
  input logic                         prog,
  input logic [7:0]                   an,
  input logic                         rx_valid,
  input logic                         wr_en,
  input logic [board_pkg::addr_w-1:0] wr_addr
);

  logic prog_q;
  logic prog_rise;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prog_q <= 1'b0;
    end else begin
      prog_q <= prog;
    end
  end

  assign prog_rise = prog & ~prog_q;

  an_one_hot: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot(~an)) else $error("an is not one-hot low");

  // a write always comes from a byte taken in program mode
  wr_en_in_prog: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(wr_en) |-> $past(prog)) else $error("wr_en rose with prog low");

  rx_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    rx_valid |=> !rx_valid) else $error("rx_valid longer than one cycle");

  load_addr_step: assert property (@(posedge clk) disable iff (!rst_n)
    (wr_addr != $past(wr_addr)) |-> $past(wr_en || prog_rise))
    else $error("wr_addr moved without a write");

endmodule : board_asserts

bind board_top board_asserts u_board_asserts (
  .clk      (clk),
  .rst_n    (rst_n),
  .prog     (prog),
  .an       (an),
  .rx_valid (rx_valid),
  .wr_en    (wr_en),
  .wr_addr  (wr_addr)
);

// File: source/board_top.sv
`timescale 1ns/1ps

module board_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        rx,
  input  logic        prog,
  input  logic        addr_up,
  input  logic        addr_dn,
  output logic [7:0]  an,
  output logic [6:0]  sev_out,
  output logic [15:0] led
);

  logic [7:0]                   rx_byte;
  logic                         rx_valid;
  logic                         wr_en;
  logic [board_pkg::addr_w-1:0] wr_addr;
  logic [board_pkg::data_w-1:0] wr_data;
  logic [board_pkg::addr_w-1:0] rd_addr;
  logic [board_pkg::data_w-1:0] rd_data;
  logic [board_pkg::data_w-1:0] disp_word;

  uart_rx u_uart_rx (
    .clk      (clk),
    .rst_n    (rst_n),
    .rx       (rx),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid)
  );

  word_loader u_word_loader (
    .clk      (clk),
    .rst_n    (rst_n),
    .prog     (prog),
    .rx_byte  (rx_byte),
    .rx_valid (rx_valid),
    .wr_en    (wr_en),
    .wr_addr  (wr_addr),
    .wr_data  (wr_data)
  );

  word_mem u_word_mem (
    .clk     (clk),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .rd_addr (rd_addr),
    .rd_data (rd_data)
  );

  debug_ctrl u_debug_ctrl (
    .clk       (clk),
    .rst_n     (rst_n),
    .prog      (prog),
    .addr_up   (addr_up),
    .addr_dn   (addr_dn),
    .wr_addr   (wr_addr),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .disp_word (disp_word)
  );

  seg_scan u_seg_scan (
    .clk       (clk),
    .rst_n     (rst_n),
    .disp_word (disp_word),
    .an        (an),
    .sev_out   (sev_out)
  );

  // leds mirror the low half of the displayed word
  assign led = disp_word[15:0];

endmodule : board_top

// File: source/seg_scan.sv
`timescale 1ns/1ps

module seg_scan (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic [board_pkg::data_w-1:0] disp_word,
  output logic [7:0]                   an,
  output logic [6:0]                   sev_out
);

  logic [board_pkg::scan_w-1:0] tick_cnt;
  logic                         tick;
  logic [2:0]                   digit;
  logic [2:0]                   digit_nxt;
  logic [3:0]                   nibble;

  assign tick      = (tick_cnt == board_pkg::scan_last);
  assign digit_nxt = digit + 3'd1;

  // scan clock enable
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      tick_cnt <= '0;
    end else if (tick) begin
      tick_cnt <= '0;
    end else begin
      tick_cnt <= tick_cnt + 1'b1;
    end
  end

  // one anode low at a time, nibble k on digit k
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      digit  <= '0;
      an     <= 8'hfe;
      nibble <= '0;
    end else if (tick) begin
      digit  <= digit_nxt;
      an     <= ~(8'd1 << digit_nxt);
      nibble <= disp_word[{digit_nxt, 2'b00} +: 4];
    end
  end

  // segments active low, bit 6 is segment a
  always_comb begin
    case (nibble)
      4'h0:    sev_out = 7'b0000001;
      4'h1:    sev_out = 7'b1001111;
      4'h2:    sev_out = 7'b0010010;
      4'h3:    sev_out = 7'b0000110;
      4'h4:    sev_out = 7'b1001100;
      4'h5:    sev_out = 7'b0100100;
      4'h6:    sev_out = 7'b0100000;
      4'h7:    sev_out = 7'b0001111;
      4'h8:    sev_out = 7'b0000000;
      4'h9:    sev_out = 7'b0000100;
      4'ha:    sev_out = 7'b0001000;
      4'hb:    sev_out = 7'b1100000;
      4'hc:    sev_out = 7'b0110001;
      4'hd:    sev_out = 7'b1000010;
      4'he:    sev_out = 7'b0110000;
      4'hf:    sev_out = 7'b0111000;
      default: sev_out = 7'b1111111;
    endcase
  end

endmodule : seg_scan

// File: source/debug_ctrl.sv
`timescale 1ns/1ps

module debug_ctrl (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         prog,
  input  logic                         addr_up,
  input  logic                         addr_dn,
  input  logic [board_pkg::addr_w-1:0] wr_addr,
  output logic [board_pkg::addr_w-1:0] rd_addr,
  input  logic [board_pkg::data_w-1:0] rd_data,
  output logic [board_pkg::data_w-1:0] disp_word
);

  logic                 up_q;
  logic                 dn_q;
  logic                 up_rise;
  logic                 dn_rise;
  board_pkg::disp_src_e disp_src;

  assign up_rise = addr_up & ~up_q;
  assign dn_rise = addr_dn & ~dn_q;

  // view address, steps one word per button press
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      up_q    <= 1'b0;
      dn_q    <= 1'b0;
      rd_addr <= '0;
    end else begin
      up_q <= addr_up;
      dn_q <= addr_dn;
      if (up_rise && !dn_rise) begin
        rd_addr <= rd_addr + 1'b1;
      end else if (dn_rise && !up_rise) begin
        rd_addr <= rd_addr - 1'b1;
      end
    end
  end

  // display source and the word it selects
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      disp_src  <= board_pkg::show_load_addr;
      disp_word <= '0;
    end else begin
      disp_src <= prog ? board_pkg::show_load_addr : board_pkg::show_mem_word;
      if (disp_src == board_pkg::show_load_addr) begin
        disp_word <= {{(board_pkg::data_w - board_pkg::addr_w){1'b0}}, wr_addr};
      end else begin
        disp_word <= rd_data;
      end
    end
  end

endmodule : debug_ctrl

// File: source/word_mem.sv
`timescale 1ns/1ps

module word_mem (
  input  logic                         clk,
  input  logic                         wr_en,
  input  logic [board_pkg::addr_w-1:0] wr_addr,
  input  logic [board_pkg::data_w-1:0] wr_data,
  input  logic [board_pkg::addr_w-1:0] rd_addr,
  output logic [board_pkg::data_w-1:0] rd_data
);

  // one word per address
  logic [board_pkg::data_w-1:0] mem [0:(1 << board_pkg::addr_w) - 1];

  // write port
  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_addr] <= wr_data;
    end
  end

  // registered read, old data on a same cycle collision
  always_ff @(posedge clk) begin
    rd_data <= mem[rd_addr];
  end

endmodule : word_mem

// File: source/word_loader.sv
`timescale 1ns/1ps

module word_loader (
  input  logic                         clk,
  input  logic                         rst_n,
  input  logic                         prog,
  input  logic [7:0]                   rx_byte,
  input  logic                         rx_valid,
  output logic                         wr_en,
  output logic [board_pkg::addr_w-1:0] wr_addr,
  output logic [board_pkg::data_w-1:0] wr_data
);

  logic       prog_q;
  logic       prog_rise;
  logic       take;
  logic [1:0] byte_cnt;

  assign prog_rise = prog & ~prog_q;

  // bytes only count in program mode
  assign take = prog & rx_valid & ~prog_rise;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      prog_q   <= 1'b0;
      byte_cnt <= '0;
      wr_addr  <= '0;
      wr_en    <= 1'b0;
    end else begin
      prog_q <= prog;
      // fourth byte completes the word
      wr_en  <= take && (byte_cnt == 2'd3);
      if (prog_rise) begin
        // new load session starts at word 0
        byte_cnt <= '0;
        wr_addr  <= '0;
      end else begin
        if (take) begin
          byte_cnt <= byte_cnt + 1'b1;
        end
        // address moves on once the write is issued, wraps at the top
        if (wr_en) begin
          wr_addr <= wr_addr + 1'b1;
        end
      end
    end
  end

  // little endian packing, first byte ends up in bits 7:0
  always_ff @(posedge clk) begin
    if (take) begin
      wr_data <= {rx_byte, wr_data[board_pkg::data_w-1:8]};
    end
  end

endmodule : word_loader

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       rx,
  output logic [7:0] rx_byte,
  output logic       rx_valid
);

  logic                        rx_meta;
  logic                        rx_sync;
  board_pkg::rx_state_e        state;
  logic [board_pkg::cnt_w-1:0] cnt;
  logic [2:0]                  bit_idx;
  logic [7:0]                  shift;

  // two flop synchroniser, line idles high
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state    <= board_pkg::idle;
      cnt      <= '0;
      bit_idx  <= '0;
      rx_valid <= 1'b0;
    end else begin
      rx_valid <= 1'b0;
      case (state)
        board_pkg::idle: begin
          cnt <= '0;
          if (!rx_sync) begin
            state <= board_pkg::start;
          end
        end
        board_pkg::start: begin
          if (cnt == board_pkg::bit_mid) begin
            cnt     <= '0;
            bit_idx <= '0;
            // glitch if the line is already back high
            state   <= rx_sync ? board_pkg::idle : board_pkg::data;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        board_pkg::data: begin
          if (cnt == board_pkg::bit_last) begin
            cnt     <= '0;
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= board_pkg::stop;
            end
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        board_pkg::stop: begin
          if (cnt == board_pkg::bit_last) begin
            state    <= board_pkg::idle;
            // framing error drops the byte
            rx_valid <= rx_sync;
          end else begin
            cnt <= cnt + 1'b1;
          end
        end
        default: state <= board_pkg::idle;
      endcase
    end
  end

  // lsb first into the shift register
  always_ff @(posedge clk) begin
    if (state == board_pkg::data && cnt == board_pkg::bit_last) begin
      shift <= {rx_sync, shift[7:1]};
    end
    if (state == board_pkg::stop && cnt == board_pkg::bit_last && rx_sync) begin
      rx_byte <= shift;
    end
  end

endmodule : uart_rx

// File: source/board_pkg.sv
package board_pkg;

  // memory geometry
  localparam int addr_w = 10;
  localparam int data_w = 32;

  // uart bit period in clock cycles
  localparam int clks_per_bit = 8;

  // display scan period in clock cycles
  localparam int scan_div = 4;

  // counter widths derived from the periods above
  localparam int cnt_w  = $clog2(clks_per_bit);
  localparam int scan_w = $clog2(scan_div);

  // counter compare points
  // bit_mid is half a bit after the start edge
  localparam logic [cnt_w-1:0] bit_mid  = cnt_w'(clks_per_bit / 2 - 1);
  localparam logic [cnt_w-1:0] bit_last = cnt_w'(clks_per_bit - 1);

  localparam logic [scan_w-1:0] scan_last = scan_w'(scan_div - 1);

  // what the display and leds show
  typedef enum logic {
    show_load_addr,
    show_mem_word
  } disp_src_e;

  // uart receiver states
  typedef enum logic [1:0] {
    idle,
    start,
    data,
    stop
  } rx_state_e;

endpackage : board_pkg
